// File: decode_stage.f
+incdir+include
verilog/common.sv
verilog/pipes.sv
verilog/decoder.sv
verilog/imm_gen.sv
verilog/regfile.sv
verilog/decode_stage.sv
sim/decode_asserts.sv
sim/decode_tb.sv

// File: include/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Machine word and register file geometry
`define XLEN 64
`define REG_COUNT 32

// RV64 major opcodes, instr[6:0]
`define F7_ALUI 7'b0010011
`define F7_ALU 7'b0110011
`define F7_ALUIW 7'b0011011
`define F7_ALUW 7'b0111011
`define F7_LUI 7'b0110111
`define F7_AUIPC 7'b0010111
`define F7_JAL 7'b1101111
`define F7_JALR 7'b1100111
`define F7_BRANCH 7'b1100011
`define F7_LD 7'b0000011
`define F7_SD 7'b0100011

// funct7 values, instr[31:25]
`define F7_FIRST_ADD 7'b0000000
`define F7_FIRST_SUB 7'b0100000
`define F7_FIRST_MUL 7'b0000001

`endif

// File: run.sh
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f decode_stage.f --top-module decode_tb -o decode_sim

./obj_dir/decode_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

// File: sim/decode_asserts.sv
`timescale 1ns/1ps

module decode_asserts (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic dec_valid,
    input pipes::decoded_t dec
);
    import pipes::*;

    logic no_write_op;

    // Stores and all six branches never write a register
    assign no_write_op = (dec.op == SD) || (dec.op == BEQ) || (dec.op == BNE) ||
                         (dec.op == BLT) || (dec.op == BGE) ||
                         (dec.op == BLTU) || (dec.op == BGEU);

    reset_release: assert property (@(posedge clk) $rose(rst_n) |=> !dec_valid)
        else $error("dec_valid high in the first cycle after reset");

    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (dec_valid == $past(instr_valid)))
        else $error("dec_valid does not follow instr_valid by one cycle");

    no_write_on_store_branch: assert property (@(posedge clk) disable iff (!rst_n)
        (dec_valid && no_write_op) |-> !dec.regwrite)
        else $error("regwrite set on a store or branch");

endmodule

bind decode_stage decode_asserts u_asserts (
    .clk(clk),
    .rst_n(rst_n),
    .instr_valid(instr_valid),
    .dec_valid(dec_valid),
    .dec(dec)
);

// File: sim/decode_tb.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_tb;
    import common::*;
    import pipes::*;

    localparam logic [31:0] LFSR_SEED = 32'hcf8a_90ee;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    // Rough cycle budget of all tests
    localparam int TEST_CYCLES = 450;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic clk;
    logic rst_n;
    logic [31:0] instr;
    logic instr_valid;
    logic wb_en;
    reg_idx_t wb_rd;
    word_t wb_data;
    decoded_t dec;
    logic dec_valid;

    logic [31:0] lfsr;
    int errors;
    int checks;
    int cycles = 0;

    decode_stage dut (
        .clk(clk),
        .rst_n(rst_n),
        .instr(instr),
        .instr_valid(instr_valid),
        .wb_en(wb_en),
        .wb_rd(wb_rd),
        .wb_data(wb_data),
        .dec(dec),
        .dec_valid(dec_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `F7_SD};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `F7_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `F7_JAL};
    endfunction

    // RV64IM function for the ALU opcodes
    // MULH variants fall back to the base op
    function automatic alufunc_t exp_func(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [6:0] f7);
        logic is_reg;
        logic mul;
        logic alt;
        alufunc_t f;
        is_reg = (opc == `F7_ALU) || (opc == `F7_ALUW);
        mul = is_reg && (f7 == `F7_FIRST_MUL);
        alt = f7[5];
        case (f3)
            3'd0: f = mul ? MULT : ((is_reg && alt) ? SUB : ADD);
            3'd1: f = SLL;
            3'd2: f = SLT;
            3'd3: f = SLTU;
            3'd4: f = mul ? DIV : XOR;
            3'd5: f = mul ? DIVU : (alt ? SRA : SRL);
            3'd6: f = mul ? REM : OR;
            default: f = mul ? REMU : AND;
        endcase
        return f;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic send_instr(input logic [31:0] w, output decoded_t d);
        @(posedge clk);
        instr <= w;
        instr_valid <= 1'b1;
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        while (!dec_valid)
            @(negedge clk);
        d = dec;
    endtask

    task automatic write_reg(input reg_idx_t r, input word_t v);
        @(posedge clk);
        wb_en <= 1'b1;
        wb_rd <= r;
        wb_data <= v;
        @(posedge clk);
        wb_en <= 1'b0;
    endtask

    task automatic expect_decode(input decoded_t d, input decode_op_t op,
                                 input alufunc_t func, input logic rw);
        check("op", 64'(d.op), 64'(op));
        check("alufunc", 64'(d.alufunc), 64'(func));
        check("regwrite", 64'(d.regwrite), 64'(rw));
    endtask

    task automatic test_alu();
        logic [6:0] opcs [4];
        logic [6:0] f7s [3];
        decode_op_t ops [4];
        decoded_t d;
        opcs = '{`F7_ALUI, `F7_ALU, `F7_ALUIW, `F7_ALUW};
        ops = '{ALUI, ALU, ALUIW, ALUW};
        f7s = '{`F7_FIRST_ADD, `F7_FIRST_SUB, `F7_FIRST_MUL};
        for (int o = 0; o < 4; o++) begin
            for (int f = 0; f < 3; f++) begin
                for (int k = 0; k < 8; k++) begin
                    send_instr(enc_r(f7s[f], 5'd3, 5'd2, 3'(k), 5'd1, opcs[o]), d);
                    expect_decode(d, ops[o], exp_func(opcs[o], 3'(k), f7s[f]), 1'b1);
                end
            end
        end
    endtask

    task automatic test_imm();
        logic [11:0] i12;
        logic [12:0] b13;
        logic [19:0] u20;
        logic [20:0] j21;
        decoded_t d;
        for (int n = 0; n < 6; n++) begin
            i12 = 12'(rand_bits(12));
            send_instr(enc_i(i12, 5'd4, 3'd0, 5'd9,
                             n[0] ? `F7_LD : (n[1] ? `F7_JALR : `F7_ALUIW)), d);
            check("imm_i", d.imm, {{52{i12[11]}}, i12});
            check("rd", 64'(d.rd), 64'd9);
            i12 = 12'(rand_bits(12));
            send_instr(enc_s(i12, 5'd6, 5'd5, 3'd3), d);
            check("imm_s", d.imm, {{52{i12[11]}}, i12});
            b13 = {12'(rand_bits(12)), 1'b0};
            send_instr(enc_b(b13, 5'd6, 5'd5, 3'd1), d);
            check("imm_b", d.imm, {{51{b13[12]}}, b13});
            u20 = 20'(rand_bits(20));
            send_instr(enc_u(u20, 5'd10, n[0] ? `F7_AUIPC : `F7_LUI), d);
            check("imm_u", d.imm, {{32{u20[19]}}, u20, 12'h000});
            j21 = {20'(rand_bits(20)), 1'b0};
            send_instr(enc_j(j21, 5'd1), d);
            check("imm_j", d.imm, {{43{j21[20]}}, j21});
        end
        send_instr(enc_r(7'h7f, 5'd31, 5'd31, 3'd7, 5'd31, `F7_ALU), d);
        check("imm_r", d.imm, 64'd0);
    endtask

    task automatic test_control();
        logic [2:0] bf3 [6];
        decode_op_t bops [6];
        alufunc_t bfuncs [6];
        decoded_t d;
        bf3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        bops = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        bfuncs = '{COMPARE, COMPARE, SLT, SLT, SLTU, SLTU};
        for (int i = 0; i < 6; i++) begin
            send_instr(enc_b(13'h010, 5'd2, 5'd1, bf3[i]), d);
            expect_decode(d, bops[i], bfuncs[i], 1'b0);
        end
        send_instr(enc_i(12'h008, 5'd1, 3'd3, 5'd5, `F7_LD), d);
        expect_decode(d, LD, ADD, 1'b1);
        send_instr(enc_i(12'h004, 5'd1, 3'd0, 5'd1, `F7_JALR), d);
        expect_decode(d, JALR, ADD, 1'b1);
        send_instr(enc_u(20'h12345, 5'd3, `F7_AUIPC), d);
        expect_decode(d, AUIPC, ADD, 1'b1);
        send_instr(enc_j(21'h00100, 5'd1), d);
        expect_decode(d, JAL, ADD, 1'b1);
        send_instr(enc_s(12'h010, 5'd2, 5'd1, 3'd3), d);
        expect_decode(d, SD, ADD, 1'b0);
        send_instr(enc_u(20'hfffff, 5'd3, `F7_LUI), d);
        expect_decode(d, LUI, CPYB, 1'b1);
        send_instr(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd2, 7'b1111111), d);
        expect_decode(d, ALUI, ADD, 1'b0);
    endtask

    task automatic test_regfile();
        word_t model [32];
        reg_idx_t r;
        word_t v;
        decoded_t d;
        for (int k = 0; k < 32; k++)
            model[k] = '0;
        for (int n = 0; n < 16; n++) begin
            r = 5'(rand_bits(5));
            v = rand_bits(64);
            write_reg(r, v);
            if (r != 5'd0)
                model[r] = v;
        end
        for (int k = 0; k < 32; k++) begin
            send_instr(enc_r(7'h00, 5'(31 - k), 5'(k), 3'd0, 5'd0, `F7_ALU), d);
            check("src1", d.src1, model[k]);
            check("src2", d.src2, model[31 - k]);
        end
        write_reg(5'd0, rand_bits(64));
        send_instr(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, `F7_ALU), d);
        check("src1", d.src1, 64'd0);
        check("src2", d.src2, 64'd0);
        // Writeback and decode of the same register in one cycle
        v = rand_bits(64);
        @(posedge clk);
        instr <= enc_r(7'h00, 5'd7, 5'd7, 3'd0, 5'd0, `F7_ALU);
        instr_valid <= 1'b1;
        wb_en <= 1'b1;
        wb_rd <= 5'd7;
        wb_data <= v;
        @(posedge clk);
        instr_valid <= 1'b0;
        wb_en <= 1'b0;
        @(negedge clk);
        check("dec_valid", 64'(dec_valid), 64'd1);
        check("src1", dec.src1, v);
        check("src2", dec.src2, v);
        send_instr(enc_r(7'h00, 5'd7, 5'd7, 3'd0, 5'd0, `F7_ALU), d);
        check("src1", d.src1, v);
        // A fresh reset clears every written register
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("dec_valid", 64'(dec_valid), 64'd0);
        for (int k = 0; k < 32; k += 2) begin
            send_instr(enc_r(7'h00, 5'(k + 1), 5'(k), 3'd0, 5'd0, `F7_ALU), d);
            check("src1", d.src1, 64'd0);
            check("src2", d.src2, 64'd0);
        end
    endtask

    task automatic test_burst();
        logic [31:0] words [6];
        word_t exp_imm [6];
        logic [11:0] i12;
        for (int k = 0; k < 6; k++) begin
            i12 = 12'(rand_bits(12));
            words[k] = enc_i(i12, 5'd0, 3'd0, 5'(k + 1), `F7_ALUI);
            exp_imm[k] = {{52{i12[11]}}, i12};
        end
        for (int k = 0; k <= 6; k++) begin
            @(posedge clk);
            if (k < 6) begin
                instr <= words[k];
                instr_valid <= 1'b1;
            end else begin
                instr_valid <= 1'b0;
            end
            @(negedge clk);
            if (k == 0) begin
                check("dec_valid", 64'(dec_valid), 64'd0);
            end else begin
                check("dec_valid", 64'(dec_valid), 64'd1);
                check("imm", dec.imm, exp_imm[k - 1]);
                check("rd", 64'(dec.rd), 64'(k));
            end
        end
        // Idle cycles keep the last bundle
        repeat (4) begin
            @(negedge clk);
            check("dec_valid", 64'(dec_valid), 64'd0);
            check("imm", dec.imm, exp_imm[5]);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        lfsr = LFSR_SEED;
        rst_n = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        wb_en = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("dec_valid", 64'(dec_valid), 64'd0);
        test_regfile();
        test_alu();
        test_imm();
        test_control();
        test_burst();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verilog/common.sv
`include "decode_consts.svh"

package common;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t rs2;
        reg_idx_t rs1;
        logic [2:0] funct3;
        reg_idx_t rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t rs1;
        logic [2:0] funct3;
        reg_idx_t rd;
        logic [6:0] opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t rs2;
        reg_idx_t rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset is scattered, bit 0 is implied zero
    typedef struct packed {
        logic imm12;
        logic [5:0] imm10_5;
        reg_idx_t rs2;
        reg_idx_t rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t rd;
        logic [6:0] opcode;
    } u_fmt_t;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10_1;
        logic imm11;
        logic [7:0] imm19_12;
        reg_idx_t rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input logic clk,
    input logic rst_n,
    input logic [31:0] instr,
    input logic instr_valid,
    input logic wb_en,
    input common::reg_idx_t wb_rd,
    input common::word_t wb_data,
    output pipes::decoded_t dec,
    output logic dec_valid
);
    import common::*;
    import pipes::*;

    instr_u instr_w;
    decode_op_t op;
    alufunc_t alufunc;
    logic regwrite;
    word_t imm;
    word_t src1;
    word_t src2;
    decoded_t dec_next;

    assign instr_w = instr_u'(instr);

    decoder u_decoder (
        .instr(instr),
        .op(op),
        .alufunc(alufunc),
        .regwrite(regwrite)
    );

    imm_gen u_imm_gen (
        .instr(instr_w),
        .imm(imm)
    );

    // Read addresses come straight from the R layout, unused fields are harmless
    regfile u_regfile (
        .clk(clk),
        .rst_n(rst_n),
        .rs1(instr_w.r_fmt.rs1),
        .rs2(instr_w.r_fmt.rs2),
        .src1(src1),
        .src2(src2),
        .wen(wb_en),
        .rd(wb_rd),
        .wdata(wb_data)
    );

    always_comb begin
        dec_next.op = op;
        dec_next.alufunc = alufunc;
        dec_next.regwrite = regwrite;
        dec_next.rd = instr_w.r_fmt.rd;
        dec_next.imm = imm;
        dec_next.src1 = src1;
        dec_next.src2 = src2;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec <= '0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
            if (instr_valid)
                dec <= dec_next;
        end
    end

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module decoder (
    input logic [31:0] instr,
    output pipes::decode_op_t op,
    output pipes::alufunc_t alufunc,
    output logic regwrite
);
    import pipes::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] f7_first;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign f7_first = instr[31:25];

    // Immediate forms only look at bit 30 for the shift kind
    function automatic alufunc_t imm_func(input logic [2:0] f3, input logic arith);
        case (f3)
            3'b000: imm_func = ADD;
            3'b100: imm_func = XOR;
            3'b110: imm_func = OR;
            3'b111: imm_func = AND;
            3'b010: imm_func = SLT;
            3'b011: imm_func = SLTU;
            3'b001: imm_func = SLL;
            default: imm_func = arith ? SRA : SRL;
        endcase
    endfunction

    // Register forms, funct7 picks base or M extension
    function automatic alufunc_t reg_func(input logic [2:0] f3, input logic [6:0] f7);
        logic m_ext;
        logic sub;
        m_ext = (f7 == `F7_FIRST_MUL);
        sub = (f7 == `F7_FIRST_SUB);
        case (f3)
            3'b000: begin
                if (sub)
                    reg_func = SUB;
                else if (m_ext)
                    reg_func = MULT;
                else
                    reg_func = ADD;
            end
            3'b100: reg_func = m_ext ? DIV : XOR;
            3'b110: reg_func = m_ext ? REM : OR;
            3'b111: reg_func = m_ext ? REMU : AND;
            3'b010: reg_func = SLT;
            3'b011: reg_func = SLTU;
            3'b001: reg_func = SLL;
            default: begin
                if (sub)
                    reg_func = SRA;
                else if (m_ext)
                    reg_func = DIVU;
                else
                    reg_func = SRL;
            end
        endcase
    endfunction

    always_comb begin
        // Unknown opcodes fall through as a harmless non-writing ALUI
        op = ALUI;
        alufunc = ADD;
        regwrite = 1'b0;

        case (opcode)
            `F7_ALUI: begin
                op = ALUI;
                regwrite = 1'b1;
                alufunc = imm_func(funct3, instr[30]);
            end
            `F7_ALU: begin
                op = ALU;
                regwrite = 1'b1;
                alufunc = reg_func(funct3, f7_first);
            end
            `F7_ALUIW: begin
                op = ALUIW;
                regwrite = 1'b1;
                alufunc = imm_func(funct3, instr[30]);
            end
            `F7_ALUW: begin
                op = ALUW;
                regwrite = 1'b1;
                alufunc = reg_func(funct3, f7_first);
            end
            `F7_LUI: begin
                op = LUI;
                regwrite = 1'b1;
                alufunc = CPYB;
            end
            `F7_AUIPC: begin
                op = AUIPC;
                regwrite = 1'b1;
            end
            `F7_JAL: begin
                op = JAL;
                regwrite = 1'b1;
            end
            `F7_JALR: begin
                op = JALR;
                regwrite = 1'b1;
            end
            `F7_BRANCH: begin
                case (funct3)
                    3'b000: begin
                        op = BEQ;
                        alufunc = COMPARE;
                    end
                    3'b001: begin
                        op = BNE;
                        alufunc = COMPARE;
                    end
                    3'b100: begin
                        op = BLT;
                        alufunc = SLT;
                    end
                    3'b101: begin
                        op = BGE;
                        alufunc = SLT;
                    end
                    3'b110: begin
                        op = BLTU;
                        alufunc = SLTU;
                    end
                    3'b111: begin
                        op = BGEU;
                        alufunc = SLTU;
                    end
                    default: begin
                        op = ALUI;
                        alufunc = ADD;
                    end
                endcase
            end
            `F7_LD: begin
                op = LD;
                regwrite = 1'b1;
            end
            `F7_SD: begin
                op = SD;
            end
            default: begin
                op = ALUI;
                regwrite = 1'b0;
            end
        endcase
    end

endmodule

// File: verilog/imm_gen.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module imm_gen (
    input common::instr_u instr,
    output common::word_t imm
);
    import common::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign imm_i = {{(`XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};

    assign imm_s = {{(`XLEN-12){instr.s_fmt.imm_hi[6]}},
                    instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};

    assign imm_b = {{(`XLEN-13){instr.b_fmt.imm12}},
                    instr.b_fmt.imm12, instr.b_fmt.imm11,
                    instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};

    // Upper immediate sits at bit 12 and still sign-extends to XLEN
    assign imm_u = {{(`XLEN-32){instr.u_fmt.imm[19]}}, instr.u_fmt.imm, 12'b0};

    assign imm_j = {{(`XLEN-21){instr.j_fmt.imm20}},
                    instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                    instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};

    always_comb begin
        case (instr.r_fmt.opcode)
            `F7_ALUI, `F7_ALUIW, `F7_LD, `F7_JALR: imm = imm_i;
            `F7_SD: imm = imm_s;
            `F7_BRANCH: imm = imm_b;
            `F7_LUI, `F7_AUIPC: imm = imm_u;
            `F7_JAL: imm = imm_j;
            // R-type carries no immediate
            default: imm = '0;
        endcase
    end

endmodule

// File: verilog/pipes.sv
package pipes;

    typedef enum logic [3:0] {
        ALUI,
        ALU,
        ALUIW,
        ALUW,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LD,
        SD
    } decode_op_t;

    typedef enum logic [4:0] {
        ADD,
        SUB,
        XOR,
        OR,
        AND,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        MULT,
        DIV,
        DIVU,
        REM,
        REMU,
        CPYB,
        COMPARE
    } alufunc_t;

    // Bundle handed to execute
    typedef struct packed {
        decode_op_t op;
        alufunc_t alufunc;
        logic regwrite;
        common::reg_idx_t rd;
        common::word_t imm;
        common::word_t src1;
        common::word_t src2;
    } decoded_t;

endpackage

// File: verilog/regfile.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module regfile (
    input logic clk,
    input logic rst_n,
    input common::reg_idx_t rs1,
    input common::reg_idx_t rs2,
    output common::word_t src1,
    output common::word_t src2,
    input logic wen,
    input common::reg_idx_t rd,
    input common::word_t wdata
);
    import common::*;

    // x0 has no storage
    word_t regs [1:`REG_COUNT-1];
    logic wr_live;

    assign wr_live = wen && (rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle write wins over the stored value
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0)
            read_port = '0;
        else if (wr_live && (idx == rd))
            read_port = wdata;
        else
            read_port = regs[idx];
    endfunction

    always_comb begin
        src1 = read_port(rs1);
        src2 = read_port(rs2);
    end

endmodule
